//--- battle_macros.svh
`ifndef BATTLE_MACROS_SVH
`define BATTLE_MACROS_SVH

//////////////////////////////////////////////////
// board geometry
//////////////////////////////////////////////////

`define BOARD_COLS 10 // cells across
`define BOARD_ROWS 10 // cells down
`define BOARD_CELLS (`BOARD_COLS * `BOARD_ROWS)

`define CELL_W 64 // pixels per cell in x
`define CELL_H 48 // pixels per cell in y

//////////////////////////////////////////////////
// shooter random source
//////////////////////////////////////////////////

`define LFSR_SEED 8'hA5
// taps at bits 7 5 4 3 for x^8+x^6+x^5+x^4+1
`define LFSR_TAPS 8'hB8

// cycles from address to rd_data in grid_ram
`define RAM_RD_LAT 1

`endif

//--- battle_pkg.sv
package battle_pkg;

	// column or row index on the board
	typedef logic [3:0] cell_coord_t;

	// mouse coordinate in pixels
	typedef logic [9:0] pixel_t;

	// occupied and unhit cells, up to 100
	typedef logic [6:0] ship_count_t;

	// shooter lfsr state
	typedef logic [7:0] lfsr_t;

	// marks a pointer off the board
	localparam cell_coord_t no_cell = 4'hF;

	// status codes of one cell
	typedef enum logic [1:0]
	{
		free     = 2'b00,
		occ      = 2'b01,
		hit      = 2'b10,
		outbound = 2'b11 // only shown on cell_status, never stored
	} cell_status_e;

	// phases of the game
	typedef enum logic [1:0]
	{
		turn_deploy = 2'b00,
		turn_player = 2'b01,
		turn_ai     = 2'b10,
		turn_over   = 2'b11
	} turn_e;

endpackage

//--- grid_if.sv
`timescale 1ns/1ns

// one access port of the cell status ram
interface grid_if;

	battle_pkg::cell_coord_t col; // target column
	battle_pkg::cell_coord_t row; // target row
	logic wr_en;                  // single cycle write strobe
	battle_pkg::cell_status_e wr_data;
	battle_pkg::cell_status_e rd_data; // one cycle after col/row

	// engine or shooter side
	modport requester
	(
		output col,
		output row,
		output wr_en,
		output wr_data,
		input rd_data
	);

	// ram side
	modport memory
	(
		input col,
		input row,
		input wr_en,
		input wr_data,
		output rd_data
	);

endinterface

//--- grid_ram.sv
`timescale 1ns/1ns
`include "battle_macros.svh"

module grid_ram
(
	input logic clk_in,
	input logic rst,
	grid_if.memory eng_port,
	grid_if.memory ai_port
);

	battle_pkg::cell_status_e mem [0:`BOARD_CELLS-1]; // row * 10 + col

	logic [6:0] clr_idx;  // entry being cleared
	logic clr_busy;       // clear sweep still running
	logic [7:0] eng_idx;
	logic [7:0] ai_idx;

	// flat index, up to 165 for the no_cell code
	function automatic logic [7:0] cell_index
	(
		input battle_pkg::cell_coord_t col,
		input battle_pkg::cell_coord_t row
	);
		cell_index = 8'(row) * 8'(`BOARD_COLS) + 8'(col);
	endfunction

	assign eng_idx = cell_index(eng_port.col, eng_port.row);
	assign ai_idx = cell_index(ai_port.col, ai_port.row);

	//////////////////////////////////////////////////
	// clear sweep after reset
	//////////////////////////////////////////////////

	always_ff @(posedge clk_in)
	begin
		if (rst)
		begin
			clr_idx <= '0;
			clr_busy <= 1'b1;
		end
		else if (clr_busy)
		begin
			clr_idx <= clr_idx + 7'd1;
			if (clr_idx == 7'(`BOARD_CELLS - 1))
				clr_busy <= 1'b0; // last entry written this edge
		end
	end

	// writes, held off while sweeping
	always_ff @(posedge clk_in)
	begin
		if (clr_busy)
			mem[clr_idx] <= battle_pkg::free;
		else
		begin
			if (eng_port.wr_en && eng_idx < 8'(`BOARD_CELLS))
				mem[eng_idx[6:0]] <= eng_port.wr_data;
			if (ai_port.wr_en && ai_idx < 8'(`BOARD_CELLS))
				mem[ai_idx[6:0]] <= ai_port.wr_data;
		end
	end

	// synchronous reads, off-board reads as free
	always_ff @(posedge clk_in)
	begin
		eng_port.rd_data <= (eng_idx < 8'(`BOARD_CELLS)) ? mem[eng_idx[6:0]] : battle_pkg::free;
		ai_port.rd_data <= (ai_idx < 8'(`BOARD_CELLS)) ? mem[ai_idx[6:0]] : battle_pkg::free;
	end

endmodule

//--- grid_engine.sv
`timescale 1ns/1ns
`include "battle_macros.svh"

module grid_engine
(
	input logic clk_in,
	input logic rst,
	input battle_pkg::pixel_t mouse_pos_x,
	input battle_pkg::pixel_t mouse_pos_y,
	input logic mouse_click,
	input logic start,
	input logic ai_fire,
	input logic ai_hit,
	output battle_pkg::cell_coord_t cell_x,
	output battle_pkg::cell_coord_t cell_y,
	output battle_pkg::cell_status_e cell_status,
	output battle_pkg::turn_e turn,
	output battle_pkg::ship_count_t ships_left,
	output logic ai_go,
	grid_if.requester ram
);

	// click read-modify-write phases
	typedef enum logic [1:0] {ck_idle, ck_read, ck_write} click_e;

	click_e phase;
	battle_pkg::pixel_t pos_x_q;    // pointer seen last edge
	battle_pkg::pixel_t pos_y_q;
	logic [1:0] steady_cnt;         // edges without movement, saturates at 2
	logic still;
	logic on_board;
	logic oob_q;                    // lines up with rd_data
	battle_pkg::cell_coord_t clk_col; // latched click target
	battle_pkg::cell_coord_t clk_row;
	battle_pkg::cell_status_e new_status;
	logic ship_inc;
	logic ship_dec;
	logic start_ok;
	logic click_ok;
	battle_pkg::ship_count_t ships_after_ai;

	assign on_board = (mouse_pos_x < 10'(`BOARD_COLS * `CELL_W)) &&
		(mouse_pos_y < 10'(`BOARD_ROWS * `CELL_H));
	assign still = (mouse_pos_x == pos_x_q) && (mouse_pos_y == pos_y_q);

	//////////////////////////////////////////////////
	// pointer to cell mapping
	//////////////////////////////////////////////////

	always_ff @(posedge clk_in)
	begin
		if (rst)
		begin
			pos_x_q <= '0;
			pos_y_q <= '0;
			steady_cnt <= '0;
			cell_x <= battle_pkg::no_cell;
			cell_y <= battle_pkg::no_cell;
			oob_q <= 1'b1;
		end
		else
		begin
			pos_x_q <= mouse_pos_x;
			pos_y_q <= mouse_pos_y;
			if (!still)
				steady_cnt <= '0; // moved, start over
			else if (steady_cnt != 2'd2)
				steady_cnt <= steady_cnt + 2'd1;
			if (on_board)
			begin
				cell_x <= 4'(mouse_pos_x / `CELL_W);
				cell_y <= 4'(mouse_pos_y / `CELL_H);
			end
			else
			begin
				cell_x <= battle_pkg::no_cell;
				cell_y <= battle_pkg::no_cell;
			end
			oob_q <= (cell_x == battle_pkg::no_cell);
		end
	end

	assign cell_status = oob_q ? battle_pkg::outbound : ram.rd_data;

	// display address unless a click owns the port
	assign ram.col = (phase == ck_idle) ? cell_x : clk_col;
	assign ram.row = (phase == ck_idle) ? cell_y : clk_row;
	assign ram.wr_en = (phase == ck_write);
	assign ram.wr_data = new_status;

	// next status of the clicked cell
	always_comb
	begin
		new_status = ram.rd_data;
		ship_inc = 1'b0;
		ship_dec = 1'b0;
		case (turn)
			battle_pkg::turn_deploy:
			begin
				if (ram.rd_data == battle_pkg::free)
				begin
					new_status = battle_pkg::occ; // place
					ship_inc = 1'b1;
				end
				else if (ram.rd_data == battle_pkg::occ)
				begin
					new_status = battle_pkg::free; // take back
					ship_dec = 1'b1;
				end
			end
			battle_pkg::turn_player:
			begin
				if (ram.rd_data == battle_pkg::occ)
				begin
					new_status = battle_pkg::hit;
					ship_dec = 1'b1;
				end
			end
			default: ; // no clicks in ai or over
		endcase
	end

	assign start_ok = start && (turn == battle_pkg::turn_deploy) && (phase == ck_idle);
	assign click_ok = mouse_click && !start && (phase == ck_idle) && still &&
		(steady_cnt == 2'd2) && (cell_x != battle_pkg::no_cell) &&
		(turn == battle_pkg::turn_deploy || turn == battle_pkg::turn_player);
	assign ships_after_ai = (ai_hit && ships_left != '0) ? ships_left - 7'd1 : ships_left;

	//////////////////////////////////////////////////
	// turn fsm and ship counter
	//////////////////////////////////////////////////

	always_ff @(posedge clk_in)
	begin
		if (rst)
		begin
			phase <= ck_idle;
			turn <= battle_pkg::turn_deploy;
			ships_left <= '0;
			ai_go <= 1'b0;
		end
		else
		begin
			ai_go <= 1'b0; // single pulse
			case (phase)
				ck_idle: if (click_ok) phase <= ck_read; // edge 1
				ck_read: phase <= ck_write;              // edge 2
				ck_write:                                // edge 3
				begin
					phase <= ck_idle;
					if (ship_inc)
						ships_left <= ships_left + 7'd1;
					else if (ship_dec)
						ships_left <= ships_left - 7'd1;
					if (turn == battle_pkg::turn_player)
					begin
						turn <= battle_pkg::turn_ai; // any board click passes the turn
						ai_go <= 1'b1;
					end
				end
				default: phase <= ck_idle;
			endcase
			if (start_ok)
				turn <= battle_pkg::turn_player;
			if (ai_fire && turn == battle_pkg::turn_ai)
			begin
				ships_left <= ships_after_ai;
				turn <= (ships_after_ai == '0) ? battle_pkg::turn_over : battle_pkg::turn_player;
			end
		end
	end

	// click target
	always_ff @(posedge clk_in)
	begin
		if (click_ok)
		begin
			clk_col <= cell_x;
			clk_row <= cell_y;
		end
	end

endmodule

//--- ai_shooter.sv
`timescale 1ns/1ns
`include "battle_macros.svh"

module ai_shooter
(
	input logic clk_in,
	input logic rst,
	input logic ai_go,
	output logic ai_fire,
	output logic ai_hit,
	output battle_pkg::cell_coord_t ai_cell_x,
	output battle_pkg::cell_coord_t ai_cell_y,
	grid_if.requester ram
);

	typedef enum logic [1:0] {idle, step, read, fire} shoot_e;

	shoot_e state;
	battle_pkg::lfsr_t lfsr;
	battle_pkg::lfsr_t lfsr_next;
	logic on_board;
	logic accept;

	// fibonacci lfsr shifting left
	assign lfsr_next = {lfsr[6:0], ^(lfsr & `LFSR_TAPS)};

	// next candidate goes out during step so read sees its data
	assign ram.col = (state == step) ? lfsr_next[3:0] : lfsr[3:0];
	assign ram.row = (state == step) ? lfsr_next[7:4] : lfsr[7:4];

	assign on_board = (lfsr[3:0] < 4'(`BOARD_COLS)) && (lfsr[7:4] < 4'(`BOARD_ROWS));
	assign accept = (state == read) && on_board &&
		(ram.rd_data != battle_pkg::hit);

	// occ turns to hit and free is written back as is
	assign ram.wr_en = accept;
	assign ram.wr_data = (ram.rd_data == battle_pkg::occ) ? battle_pkg::hit : ram.rd_data;

	assign ai_fire = (state == fire);

	//////////////////////////////////////////////////
	// target search
	//////////////////////////////////////////////////

	always_ff @(posedge clk_in)
	begin
		if (rst)
		begin
			state <= idle;
			lfsr <= `LFSR_SEED;
			ai_hit <= 1'b0;
			ai_cell_x <= battle_pkg::no_cell;
			ai_cell_y <= battle_pkg::no_cell;
		end
		else
		begin
			case (state)
				idle: if (ai_go) state <= step;
				step:
				begin
					lfsr <= lfsr_next; // new candidate
					state <= read;
				end
				read:
				begin
					if (accept)
					begin
						ai_cell_x <= lfsr[3:0];
						ai_cell_y <= lfsr[7:4];
						ai_hit <= (ram.rd_data == battle_pkg::occ);
						state <= fire;
					end
					else
						state <= step; // off board or already hit so draw again
				end
				fire: state <= idle;
				default: state <= idle;
			endcase
		end
	end

endmodule

//--- battle_top.sv
`timescale 1ns/1ns

module battle_top
(
	input logic clk_in,
	input logic rst,
	input battle_pkg::pixel_t mouse_pos_x,
	input battle_pkg::pixel_t mouse_pos_y,
	input logic mouse_click,
	input logic start,
	output battle_pkg::cell_coord_t cell_x,
	output battle_pkg::cell_coord_t cell_y,
	output battle_pkg::cell_status_e cell_status,
	output battle_pkg::turn_e turn,
	output battle_pkg::ship_count_t ships_left,
	output logic ai_fire,
	output battle_pkg::cell_coord_t ai_cell_x,
	output battle_pkg::cell_coord_t ai_cell_y
);

	logic ai_go;  // engine asks for a shot
	logic ai_hit; // shot result, valid with ai_fire

	grid_if eng_port(); // pointer and click side
	grid_if ai_port();  // shooter side

	grid_ram u_grid_ram
	(
		.clk_in   (clk_in),
		.rst      (rst),
		.eng_port (eng_port),
		.ai_port  (ai_port)
	);

	grid_engine u_grid_engine
	(
		.clk_in      (clk_in),
		.rst         (rst),
		.mouse_pos_x (mouse_pos_x),
		.mouse_pos_y (mouse_pos_y),
		.mouse_click (mouse_click),
		.start       (start),
		.ai_fire     (ai_fire),
		.ai_hit      (ai_hit),
		.cell_x      (cell_x),
		.cell_y      (cell_y),
		.cell_status (cell_status),
		.turn        (turn),
		.ships_left  (ships_left),
		.ai_go       (ai_go),
		.ram         (eng_port)
	);

	ai_shooter u_ai_shooter
	(
		.clk_in    (clk_in),
		.rst       (rst),
		.ai_go     (ai_go),
		.ai_fire   (ai_fire),
		.ai_hit    (ai_hit),
		.ai_cell_x (ai_cell_x),
		.ai_cell_y (ai_cell_y),
		.ram       (ai_port)
	);

endmodule

//--- battle_properties.sv
`timescale 1ns/1ns
`include "battle_macros.svh"

module battle_properties
(
	input logic clk_in,
	input logic rst,
	input logic ai_fire,
	input battle_pkg::cell_coord_t ai_cell_x,
	input battle_pkg::cell_coord_t ai_cell_y,
	input battle_pkg::turn_e turn,
	input battle_pkg::ship_count_t ships_left
);

	//////////////////////////////////////////////////
	// shooter handshake
	//////////////////////////////////////////////////

	// shooter only fires while it owns the turn
	ai_fire_in_ai_turn: assert property (@(posedge clk_in) disable iff (rst)
		ai_fire |-> (turn == battle_pkg::turn_ai))
		else $error("ai_fire seen outside the ai turn");

	ai_fire_one_cycle: assert property (@(posedge clk_in) disable iff (rst)
		ai_fire |=> !ai_fire) // strobe, never a level
		else $error("ai_fire held for more than one cycle");

	// target must be a real cell
	ai_target_on_board: assert property (@(posedge clk_in) disable iff (rst)
		ai_fire |-> ((ai_cell_x < 4'(`BOARD_COLS)) && (ai_cell_y < 4'(`BOARD_ROWS))))
		else $error("ai target off the board");

	//////////////////////////////////////////////////
	// ship counter
	//////////////////////////////////////////////////

	ships_no_underflow: assert property (@(posedge clk_in) disable iff (rst)
		(ships_left == 7'h7F) |-> ($past(ships_left) != 7'h00))
		else $error("ships_left wrapped below zero");

	ships_no_overflow: assert property (@(posedge clk_in) disable iff (rst)
		(ships_left == 7'h00) |-> ($past(ships_left) != 7'h7F))
		else $error("ships_left wrapped above its maximum");

endmodule

bind battle_top battle_properties u_battle_properties
(
	.clk_in     (clk_in),
	.rst        (rst),
	.ai_fire    (ai_fire),
	.ai_cell_x  (ai_cell_x),
	.ai_cell_y  (ai_cell_y),
	.turn       (turn),
	.ships_left (ships_left)
);

//--- battle_tb.sv
`timescale 1ns/1ns
`include "battle_macros.svh"

module battle_tb;

	localparam int AI_TIMEOUT = 2000; // in cycles and well over a full lfsr period

	logic clk_in;
	logic rst;
	battle_pkg::pixel_t mouse_pos_x;
	battle_pkg::pixel_t mouse_pos_y;
	logic mouse_click;
	logic start;
	battle_pkg::cell_coord_t cell_x;
	battle_pkg::cell_coord_t cell_y;
	battle_pkg::cell_status_e cell_status;
	battle_pkg::turn_e turn;
	battle_pkg::ship_count_t ships_left;
	logic ai_fire;
	battle_pkg::cell_coord_t ai_cell_x;
	battle_pkg::cell_coord_t ai_cell_y;

	battle_pkg::cell_status_e board_exp [0:`BOARD_CELLS-1]; // scoreboard indexed row * 10 + col
	battle_pkg::ship_count_t exp_ships;
	battle_pkg::turn_e exp_turn;

	battle_top u_battle_top
	(
		.clk_in      (clk_in),
		.rst         (rst),
		.mouse_pos_x (mouse_pos_x),
		.mouse_pos_y (mouse_pos_y),
		.mouse_click (mouse_click),
		.start       (start),
		.cell_x      (cell_x),
		.cell_y      (cell_y),
		.cell_status (cell_status),
		.turn        (turn),
		.ships_left  (ships_left),
		.ai_fire     (ai_fire),
		.ai_cell_x   (ai_cell_x),
		.ai_cell_y   (ai_cell_y)
	);

	initial
	begin
		clk_in = 1'b0;
		forever #50 clk_in = ~clk_in; // 100 ns period
	end

	//////////////////////////////////////////////////
	// failure reporting and compare tasks
	//////////////////////////////////////////////////

	task automatic abort_run();
		$display(">>> FAIL");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic report_error(input string msg);
		$display("Error at %0t ns: %s", $time, msg);
		abort_run();
	endtask

	task automatic check_status(input battle_pkg::cell_status_e got,
		input battle_pkg::cell_status_e exp, input string what);
		if (got !== exp)
			report_error($sformatf("%s expected %s got %s", what, exp.name(), got.name()));
	endtask

	task automatic check_coord(input battle_pkg::cell_coord_t got,
		input battle_pkg::cell_coord_t exp, input string what);
		if (got !== exp)
			report_error($sformatf("%s expected %0d got %0d", what, exp, got));
	endtask

	task automatic check_turn(input battle_pkg::turn_e got, input battle_pkg::turn_e exp,
		input string what);
		if (got !== exp)
			report_error($sformatf("%s expected %s got %s", what, exp.name(), got.name()));
	endtask

	task automatic check_count(input battle_pkg::ship_count_t got,
		input battle_pkg::ship_count_t exp, input string what);
		if (got !== exp)
			report_error($sformatf("%s expected %0d got %0d", what, exp, got));
	endtask

	//////////////////////////////////////////////////
	// stimulus helpers
	//////////////////////////////////////////////////

	// inputs change 10 ns after the edge
	task automatic next_cycle();
		@(posedge clk_in);
		#10;
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) next_cycle();
	endtask

	task automatic apply_reset();
		rst = 1'b1;
		mouse_click = 1'b0;
		start = 1'b0;
		wait_cycles(5);
		rst = 1'b0;
		wait_cycles(110); // ram clear sweep
		for (int i = 0; i < `BOARD_CELLS; i++)
			board_exp[i] = battle_pkg::free;
		exp_ships = '0;
		exp_turn = battle_pkg::turn_deploy;
	endtask

	// random pixel inside one cell
	task automatic point_at(input int col, input int row);
		mouse_pos_x = battle_pkg::pixel_t'(col * `CELL_W + int'($urandom % `CELL_W));
		mouse_pos_y = battle_pkg::pixel_t'(row * `CELL_H + int'($urandom % `CELL_H));
	endtask

	task automatic pulse_start();
		start = 1'b1;
		next_cycle();
		start = 1'b0;
	endtask

	// scan from a random spot for a cell in the wanted state or return -1
	function automatic int find_cell(input battle_pkg::cell_status_e want);
		int first;
		int idx;
		find_cell = -1;
		first = int'($urandom % `BOARD_CELLS);
		for (int n = 0; n < `BOARD_CELLS; n++)
		begin
			idx = (first + n) % `BOARD_CELLS;
			if (find_cell < 0 && board_exp[idx] == want)
				find_cell = idx;
		end
	endfunction

	// steady pointer, one click pulse, then compare with the model
	task automatic click_cell(input int col, input int row);
		int idx;
		idx = row * `BOARD_COLS + col;
		point_at(col, row);
		wait_cycles(4); // pointer steady for more than 2 cycles
		mouse_click = 1'b1;
		next_cycle();
		mouse_click = 1'b0;
		wait_cycles(4); // write lands 2 edges after latch and readback follows
		case (exp_turn)
			battle_pkg::turn_deploy:
			begin
				if (board_exp[idx] == battle_pkg::free)
				begin
					board_exp[idx] = battle_pkg::occ;
					exp_ships = exp_ships + 7'd1;
				end
				else if (board_exp[idx] == battle_pkg::occ)
				begin
					board_exp[idx] = battle_pkg::free;
					exp_ships = exp_ships - 7'd1;
				end
			end
			battle_pkg::turn_player:
			begin
				if (board_exp[idx] == battle_pkg::occ)
				begin
					board_exp[idx] = battle_pkg::hit;
					exp_ships = exp_ships - 7'd1;
				end
				exp_turn = battle_pkg::turn_ai; // any board click passes
			end
			default: ; // ignored in ai and over
		endcase
		check_coord(cell_x, battle_pkg::cell_coord_t'(col), "cell_x at click");
		check_coord(cell_y, battle_pkg::cell_coord_t'(row), "cell_y at click");
		check_status(cell_status, board_exp[idx],
			$sformatf("cell_status after click on (%0d,%0d)", col, row));
		check_count(ships_left, exp_ships, "ships_left after click");
		check_turn(turn, exp_turn, "turn after click");
	endtask

	// wait for the shooter, judge its target, then read the cell back
	task automatic await_ai_shot();
		int waited;
		int tx;
		int ty;
		int idx;
		waited = 0;
		while (ai_fire !== 1'b1)
		begin
			if (waited >= AI_TIMEOUT)
			begin
				$display("timeout: no ai_fire within %0d cycles of the player shot", AI_TIMEOUT);
				abort_run();
			end
			next_cycle();
			waited++;
		end
		tx = int'(ai_cell_x);
		ty = int'(ai_cell_y);
		if (tx >= `BOARD_COLS || ty >= `BOARD_ROWS)
			report_error($sformatf("ai target (%0d,%0d) off the board", tx, ty));
		idx = ty * `BOARD_COLS + tx;
		if (board_exp[idx] == battle_pkg::hit)
			report_error($sformatf("ai fired on (%0d,%0d) already hit", tx, ty));
		if (board_exp[idx] == battle_pkg::occ)
		begin
			board_exp[idx] = battle_pkg::hit;
			exp_ships = exp_ships - 7'd1;
		end
		exp_turn = (exp_ships == '0) ? battle_pkg::turn_over : battle_pkg::turn_player;
		next_cycle(); // turn moves on the edge after ai_fire
		check_turn(turn, exp_turn, "turn after ai shot");
		check_count(ships_left, exp_ships, "ships_left after ai shot");
		point_at(tx, ty);
		wait_cycles(3);
		check_coord(cell_x, battle_pkg::cell_coord_t'(tx), "cell_x at ai target");
		check_coord(cell_y, battle_pkg::cell_coord_t'(ty), "cell_y at ai target");
		check_status(cell_status, board_exp[idx], "cell_status at ai target");
	endtask

	//////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////

	task automatic test_pointer_mapping();
		battle_pkg::pixel_t px;
		battle_pkg::pixel_t py;
		battle_pkg::cell_coord_t ex;
		battle_pkg::cell_coord_t ey;
		battle_pkg::cell_status_e es;
		check_turn(turn, battle_pkg::turn_deploy, "turn after reset");
		check_count(ships_left, 7'd0, "ships_left after reset");
		for (int i = 0; i < 24; i++)
		begin
			case (i)
				0:
				begin
					px = 10'd0; // top left corner
					py = 10'd0;
				end
				1:
				begin
					px = 10'd639; // last pixel on board
					py = 10'd479;
				end
				2:
				begin
					px = 10'd640; // just right of board
					py = 10'd100;
				end
				3:
				begin
					px = 10'd200; // just below
					py = 10'd480;
				end
				default:
				begin
					px = battle_pkg::pixel_t'($urandom % 1024);
					py = battle_pkg::pixel_t'($urandom % 1024);
				end
			endcase
			if (int'(px) < `BOARD_COLS * `CELL_W && int'(py) < `BOARD_ROWS * `CELL_H)
			begin
				ex = battle_pkg::cell_coord_t'(int'(px) / `CELL_W);
				ey = battle_pkg::cell_coord_t'(int'(py) / `CELL_H);
				es = board_exp[int'(ey) * `BOARD_COLS + int'(ex)];
			end
			else
			begin
				ex = 4'hF; // no cell
				ey = 4'hF;
				es = battle_pkg::outbound;
			end
			mouse_pos_x = px;
			mouse_pos_y = py;
			next_cycle();
			check_coord(cell_x, ex, $sformatf("cell_x for x=%0d", px));
			check_coord(cell_y, ey, $sformatf("cell_y for y=%0d", py));
			next_cycle();
			check_status(cell_status, es, $sformatf("cell_status for (%0d,%0d)", px, py));
		end
	endtask

	task automatic test_deployment();
		int idx;
		for (int i = 0; i < 10; i++)
			click_cell(int'($urandom % `BOARD_COLS), int'($urandom % `BOARD_ROWS));
		idx = find_cell(battle_pkg::free);
		click_cell(idx % `BOARD_COLS, idx / `BOARD_COLS); // to occ
		click_cell(idx % `BOARD_COLS, idx / `BOARD_COLS); // back to free
		click_cell(idx % `BOARD_COLS, idx / `BOARD_COLS); // keep the ship
	endtask

	task automatic test_start();
		pulse_start();
		exp_turn = battle_pkg::turn_player;
		check_turn(turn, exp_turn, "turn after start in deploy");
		pulse_start(); // no effect once playing
		next_cycle();
		check_turn(turn, exp_turn, "turn after start in player turn");
		check_count(ships_left, exp_ships, "ships_left after start");
	endtask

	task automatic test_player_shots();
		int idx;
		for (int round = 0; round < 4; round++)
		begin
			if (exp_turn == battle_pkg::turn_player)
			begin
				idx = find_cell((round % 2 == 0) ? battle_pkg::occ : battle_pkg::free);
				if (idx < 0)
				begin
					$display("no cell left in the state needed for player shot %0d", round);
					abort_run();
				end
				click_cell(idx % `BOARD_COLS, idx / `BOARD_COLS);
				await_ai_shot();
			end
		end
	endtask

	task automatic test_game_over();
		int idx;
		int free_idx;
		apply_reset();
		idx = find_cell(battle_pkg::free);
		click_cell(idx % `BOARD_COLS, idx / `BOARD_COLS); // lone ship
		check_count(ships_left, 7'd1, "ships_left with one ship");
		pulse_start();
		exp_turn = battle_pkg::turn_player;
		check_turn(turn, exp_turn, "turn after start");
		click_cell(idx % `BOARD_COLS, idx / `BOARD_COLS); // sink it
		await_ai_shot(); // turn goes to over on this shot
		check_turn(turn, battle_pkg::turn_over, "turn at game end");
		free_idx = find_cell(battle_pkg::free);
		click_cell(free_idx % `BOARD_COLS, free_idx / `BOARD_COLS); // ignored
		pulse_start();
		next_cycle();
		check_turn(turn, battle_pkg::turn_over, "turn after start in game over");
		check_count(ships_left, 7'd0, "ships_left in game over");
	endtask

	initial
	begin
		rst = 1'b1;
		mouse_pos_x = '0;
		mouse_pos_y = '0;
		mouse_click = 1'b0;
		start = 1'b0;
		void'($urandom(32'hf99));
		apply_reset();
		test_pointer_mapping();
		test_deployment();
		test_start();
		test_player_shots();
		test_game_over();
		$display(">>> PASS");
		$finish;
	end

endmodule

//--- battle_top.f
+incdir+.
battle_pkg.sv
grid_if.sv
grid_ram.sv
grid_engine.sv
ai_shooter.sv
battle_top.sv
battle_properties.sv
battle_tb.sv

//--- run.sh
#!/bin/sh
# build with verilator, then run; exit status carries the verdict
verilator --binary --timing --assert -f battle_top.f --top-module battle_tb -o battle_sim \
	&& ./obj_dir/battle_sim \
	|| { echo "battle_tb build or simulation failed"; exit 1; }
